// File: design/ex_defines.svh
/* Execute stage parameters */

`ifndef EX_DEFINES_SVH
`define EX_DEFINES_SVH

// Integer data width
`define EX_XLEN 32

// Architectural register count
`define EX_NREGS 32

// Trap vector after reset
`define EX_MTVEC_RST 32'h1000

`endif

// File: design/ex_pkg.sv
/* Execute stage types */

`include "ex_defines.svh"

package ex_pkg;

  typedef logic [`EX_XLEN-1:0] rdata_t;
  typedef logic [31:0]         pc_t;
  typedef logic [4:0]          raddr_t;

  typedef enum logic [1:0] {
    REG_RF = 2'd0,
    IMM    = 2'd1,
    ZERO   = 2'd2,
    PC     = 2'd3
  } src_op_t;

  // funct3 of OP and OP-IMM
  typedef enum logic [2:0] {
    F3_ADD_SUB = 3'd0,
    F3_SLL     = 3'd1,
    F3_SLT     = 3'd2,
    F3_SLTU    = 3'd3,
    F3_XOR     = 3'd4,
    F3_SRL_SRA = 3'd5,
    F3_OR      = 3'd6,
    F3_AND     = 3'd7
  } alu_f3_t;

  // funct3 of BRANCH
  typedef enum logic [2:0] {
    BEQ  = 3'd0,
    BNE  = 3'd1,
    BLT  = 3'd4,
    BGE  = 3'd5,
    BLTU = 3'd6,
    BGEU = 3'd7
  } branch_t;

  typedef enum logic [1:0] {
    LSU_NONE  = 2'd0,
    LSU_LOAD  = 2'd1,
    LSU_STORE = 2'd2
  } lsu_op_t;

  typedef enum logic [1:0] {
    LSU_BYTE = 2'd0,
    LSU_HALF = 2'd1,
    LSU_WORD = 2'd2
  } lsu_w_t;

  // Same codes as SYSTEM funct3
  typedef enum logic [2:0] {
    CSR_NONE = 3'd0,
    CSR_RW   = 3'd1,
    CSR_RS   = 3'd2,
    CSR_RC   = 3'd3,
    CSR_RWI  = 3'd5,
    CSR_RSI  = 3'd6,
    CSR_RCI  = 3'd7
  } csr_op_t;

  typedef struct packed {
    csr_op_t     op;
    logic [11:0] addr;
  } s_csr_t;

  typedef struct packed {
    pc_t     pc_dec;
    raddr_t  rs1_addr;
    raddr_t  rs2_addr;
    raddr_t  rd_addr;
    src_op_t rs1_op;
    src_op_t rs2_op;
    rdata_t  imm;
    alu_f3_t f3;
    logic    f7_sub;
    logic    rshift_arith;
    logic    we_rd;
    logic    branch;
    logic    jump;
    lsu_op_t lsu;
    lsu_w_t  lsu_w;
    s_csr_t  csr;
    logic    ecall;
    logic    mret;
  } s_id_ex_t;

  typedef struct packed {
    rdata_t result;
    raddr_t rd_addr;
    logic   we_rd;
  } s_ex_mem_wb_t;

  typedef struct packed {
    lsu_op_t op_typ;
    lsu_w_t  width;
    rdata_t  addr;
    rdata_t  wdata;
  } s_lsu_op_t;

  typedef struct packed {
    logic   active;
    rdata_t cause;
    rdata_t mtval;
    pc_t    pc_addr;
  } s_trap_t;

endpackage

// File: design/ex_alu.sv
/* Execute stage ALU */

module ex_alu (
  input  ex_pkg::s_id_ex_t id_ex_i,
  input  ex_pkg::rdata_t   rs1_data_i,
  input  ex_pkg::rdata_t   rs2_data_i,
  input  ex_pkg::rdata_t   fwd_value_i,
  input  logic             rs1_fwd_i,
  input  logic             rs2_fwd_i,
  output ex_pkg::rdata_t   op1_o,
  output ex_pkg::rdata_t   op2_o,
  output ex_pkg::rdata_t   res_o
);

  function automatic ex_pkg::rdata_t src_mux(ex_pkg::src_op_t sel,
                                             ex_pkg::rdata_t  rf,
                                             ex_pkg::rdata_t  imm,
                                             ex_pkg::pc_t     pc);
    ex_pkg::rdata_t val;
    case (sel)
      ex_pkg::REG_RF: val = rf;
      ex_pkg::IMM:    val = imm;
      ex_pkg::PC:     val = pc;
      default:        val = '0;
    endcase
    return val;
  endfunction

  always_comb begin
    op1_o = src_mux(id_ex_i.rs1_op, rs1_data_i, id_ex_i.imm, id_ex_i.pc_dec);
    op2_o = src_mux(id_ex_i.rs2_op, rs2_data_i, id_ex_i.imm, id_ex_i.pc_dec);

    // Stale file read replaced by last result
    if (rs1_fwd_i) begin
      op1_o = fwd_value_i;
    end
    if (rs2_fwd_i) begin
      op2_o = fwd_value_i;
    end
  end

  always_comb begin
    case (id_ex_i.f3)
      ex_pkg::F3_ADD_SUB: res_o = id_ex_i.f7_sub ? (op1_o - op2_o) : (op1_o + op2_o);
      ex_pkg::F3_SLT:     res_o = ex_pkg::rdata_t'($signed(op1_o) < $signed(op2_o));
      ex_pkg::F3_SLTU:    res_o = ex_pkg::rdata_t'(op1_o < op2_o);
      ex_pkg::F3_XOR:     res_o = op1_o ^ op2_o;
      ex_pkg::F3_OR:      res_o = op1_o | op2_o;
      ex_pkg::F3_AND:     res_o = op1_o & op2_o;
      ex_pkg::F3_SLL:     res_o = op1_o << op2_o[4:0];
      ex_pkg::F3_SRL_SRA: begin
        if (id_ex_i.rshift_arith) begin
          res_o = ex_pkg::rdata_t'($signed(op1_o) >>> op2_o[4:0]);
        end else begin
          res_o = op1_o >> op2_o[4:0];
        end
      end
      default:            res_o = '0;
    endcase
  end

endmodule

// File: design/ex_branch.sv
/* Branch and jump resolution */

module ex_branch (
  input  ex_pkg::s_id_ex_t id_ex_i,
  input  ex_pkg::rdata_t   op1_i,
  input  ex_pkg::rdata_t   op2_i,
  input  ex_pkg::rdata_t   alu_res_i,
  output logic             take_o,
  output ex_pkg::pc_t      target_o,
  output logic             misaligned_o
);

  logic cond;

  always_comb begin
    case (ex_pkg::branch_t'(id_ex_i.f3))
      ex_pkg::BEQ:  cond = (op1_i == op2_i);
      ex_pkg::BNE:  cond = (op1_i != op2_i);
      ex_pkg::BLT:  cond = ($signed(op1_i) < $signed(op2_i));
      ex_pkg::BGE:  cond = ($signed(op1_i) >= $signed(op2_i));
      ex_pkg::BLTU: cond = (op1_i < op2_i);
      ex_pkg::BGEU: cond = (op1_i >= op2_i);
      default:      cond = 1'b0;
    endcase
  end

  always_comb begin
    take_o = id_ex_i.jump || (id_ex_i.branch && cond);

    // jalr clears bit 0 of the sum
    if (id_ex_i.jump) begin
      target_o = {alu_res_i[31:1], 1'b0};
    end else begin
      target_o = id_ex_i.pc_dec + id_ex_i.imm;
    end

    // Only a taken transfer can fault
    misaligned_o = take_o && (target_o[1:0] != 2'b00);
  end

endmodule

// File: design/ex_csr.sv
/* Machine CSRs and trap entry */

`include "ex_defines.svh"

module ex_csr (
  input  logic            clk,
  input  logic            rst_i,
  input  logic            stall_i,
  input  logic            kill_i,
  input  ex_pkg::s_csr_t  csr_i,
  input  ex_pkg::rdata_t  rs1_data_i,
  input  ex_pkg::rdata_t  imm_i,
  input  ex_pkg::pc_t     pc_addr_i,
  input  logic            ecall_i,
  input  logic            mret_i,
  input  logic            misaligned_i,
  input  ex_pkg::pc_t     bad_target_i,
  output ex_pkg::rdata_t  csr_rd_o,
  output ex_pkg::s_trap_t trap_o
);

  localparam logic [11:0] ADDR_MTVEC    = 12'h305;
  localparam logic [11:0] ADDR_MSCRATCH = 12'h340;
  localparam logic [11:0] ADDR_MEPC     = 12'h341;
  localparam logic [11:0] ADDR_MCAUSE   = 12'h342;
  localparam logic [11:0] ADDR_MTVAL    = 12'h343;

  localparam ex_pkg::rdata_t CAUSE_MISALIGNED = 32'd0;
  localparam ex_pkg::rdata_t CAUSE_ECALL_M    = 32'd11;

  ex_pkg::rdata_t mtvec_ff;
  ex_pkg::rdata_t mepc_ff;
  ex_pkg::rdata_t mcause_ff;
  ex_pkg::rdata_t mtval_ff;
  ex_pkg::rdata_t mscratch_ff;
  ex_pkg::rdata_t wr_src;
  ex_pkg::rdata_t wr_val;
  logic           csr_act;
  logic           trap_enter;

  always_comb begin
    case (csr_i.addr)
      ADDR_MTVEC:    csr_rd_o = mtvec_ff;
      ADDR_MSCRATCH: csr_rd_o = mscratch_ff;
      ADDR_MEPC:     csr_rd_o = mepc_ff;
      ADDR_MCAUSE:   csr_rd_o = mcause_ff;
      ADDR_MTVAL:    csr_rd_o = mtval_ff;
      default:       csr_rd_o = '0;
    endcase
  end

  always_comb begin
    csr_act = (csr_i.op != ex_pkg::CSR_NONE) && !kill_i;
    if (csr_i.op inside {ex_pkg::CSR_RWI, ex_pkg::CSR_RSI, ex_pkg::CSR_RCI}) begin
      wr_src = ex_pkg::rdata_t'(imm_i[4:0]);
    end else begin
      wr_src = rs1_data_i;
    end
    case (csr_i.op)
      ex_pkg::CSR_RW, ex_pkg::CSR_RWI: wr_val = wr_src;
      ex_pkg::CSR_RS, ex_pkg::CSR_RSI: wr_val = csr_rd_o | wr_src;
      ex_pkg::CSR_RC, ex_pkg::CSR_RCI: wr_val = csr_rd_o & ~wr_src;
      default:                         wr_val = csr_rd_o;
    endcase
  end

  always_comb begin
    trap_o     = '0;
    trap_enter = !kill_i && (ecall_i || misaligned_i);
    if (!kill_i) begin
      if (ecall_i) begin
        trap_o.active  = 1'b1;
        trap_o.cause   = CAUSE_ECALL_M;
        trap_o.pc_addr = mtvec_ff;
      end else if (misaligned_i) begin
        trap_o.active  = 1'b1;
        trap_o.cause   = CAUSE_MISALIGNED;
        trap_o.mtval   = bad_target_i;
        trap_o.pc_addr = mtvec_ff;
      end else if (mret_i) begin
        // Return only, no state change
        trap_o.active  = 1'b1;
        trap_o.pc_addr = mepc_ff;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      mtvec_ff    <= `EX_MTVEC_RST;
      mepc_ff     <= '0;
      mcause_ff   <= '0;
      mtval_ff    <= '0;
      mscratch_ff <= '0;
    end else if (!stall_i) begin
      if (trap_enter) begin
        mepc_ff   <= pc_addr_i;
        mcause_ff <= trap_o.cause;
        mtval_ff  <= trap_o.mtval;
      end else if (csr_act) begin
        case (csr_i.addr)
          ADDR_MTVEC:    mtvec_ff    <= wr_val;
          ADDR_MSCRATCH: mscratch_ff <= wr_val;
          ADDR_MEPC:     mepc_ff     <= wr_val;
          ADDR_MCAUSE:   mcause_ff   <= wr_val;
          ADDR_MTVAL:    mtval_ff    <= wr_val;
          default:       ;
        endcase
      end
    end
  end

endmodule

// File: design/execute.sv
/* RV32I execute stage */

module execute (
  input  logic                 clk,
  input  logic                 rst_i,
  input  ex_pkg::s_id_ex_t     id_ex_i,
  input  ex_pkg::rdata_t       rs1_data_i,
  input  ex_pkg::rdata_t       rs2_data_i,
  input  logic                 id_valid_i,
  output logic                 id_ready_o,
  input  logic                 lsu_bp_i,
  output ex_pkg::s_ex_mem_wb_t ex_mem_wb_o,
  output ex_pkg::s_lsu_op_t    lsu_o,
  output logic                 fetch_req_o,
  output ex_pkg::pc_t          fetch_addr_o
);

  // Pending fetch redirect, branch/jump or trap
  typedef struct packed {
    logic        req;
    ex_pkg::pc_t addr;
  } s_redir_t;

  ex_pkg::s_ex_mem_wb_t ex_mem_wb_ff;
  ex_pkg::s_ex_mem_wb_t next_ex_mem_wb;
  s_redir_t             redir_ff;
  s_redir_t             next_redir;
  ex_pkg::rdata_t       op1;
  ex_pkg::rdata_t       op2;
  ex_pkg::rdata_t       alu_res;
  ex_pkg::rdata_t       csr_rdata;
  ex_pkg::pc_t          target;
  ex_pkg::s_trap_t      trap;
  logic                 take;
  logic                 misaligned;
  logic                 fwd_ok;
  logic                 rs1_fwd;
  logic                 rs2_fwd;
  logic                 wdata_fwd;
  logic                 accept;
  logic                 kill;
  logic                 csr_kill;

  assign id_ready_o = ~lsu_bp_i;
  assign accept     = id_valid_i & id_ready_o;
  // Instruction behind a redirect is dropped
  assign kill       = redir_ff.req;
  assign csr_kill   = kill | ~id_valid_i;

  always_comb begin
    fwd_ok    = ex_mem_wb_ff.we_rd && (ex_mem_wb_ff.rd_addr != '0);
    rs1_fwd   = fwd_ok && (id_ex_i.rs1_op == ex_pkg::REG_RF) &&
                (id_ex_i.rs1_addr == ex_mem_wb_ff.rd_addr);
    rs2_fwd   = fwd_ok && (id_ex_i.rs2_op == ex_pkg::REG_RF) &&
                (id_ex_i.rs2_addr == ex_mem_wb_ff.rd_addr);
    wdata_fwd = fwd_ok && (id_ex_i.lsu == ex_pkg::LSU_STORE) &&
                (id_ex_i.rs2_addr == ex_mem_wb_ff.rd_addr);
  end

  always_comb begin
    lsu_o.op_typ = (id_valid_i && !kill) ? id_ex_i.lsu : ex_pkg::LSU_NONE;
    lsu_o.width  = id_ex_i.lsu_w;
    lsu_o.addr   = alu_res;
    lsu_o.wdata  = wdata_fwd ? ex_mem_wb_ff.result : rs2_data_i;
  end

  always_comb begin
    next_ex_mem_wb = ex_mem_wb_ff;
    next_redir     = redir_ff;
    if (!lsu_bp_i) begin
      next_ex_mem_wb.rd_addr = id_ex_i.rd_addr;
      next_ex_mem_wb.we_rd   = accept && !kill && !trap.active && id_ex_i.we_rd &&
                               (id_ex_i.lsu == ex_pkg::LSU_NONE);
      if (id_ex_i.jump) begin
        next_ex_mem_wb.result = id_ex_i.pc_dec + 32'd4;
      end else if (id_ex_i.csr.op != ex_pkg::CSR_NONE) begin
        next_ex_mem_wb.result = csr_rdata;
      end else begin
        next_ex_mem_wb.result = alu_res;
      end

      // Trap has priority over a taken branch
      next_redir.req  = accept && !kill && (trap.active || take);
      next_redir.addr = trap.active ? trap.pc_addr : target;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      ex_mem_wb_ff <= '0;
      redir_ff     <= '0;
    end else begin
      ex_mem_wb_ff <= next_ex_mem_wb;
      redir_ff     <= next_redir;
    end
  end

  assign ex_mem_wb_o  = ex_mem_wb_ff;
  assign fetch_req_o  = redir_ff.req & ~lsu_bp_i;
  assign fetch_addr_o = redir_ff.addr;

  ex_alu u_alu (
    .id_ex_i     (id_ex_i),
    .rs1_data_i  (rs1_data_i),
    .rs2_data_i  (rs2_data_i),
    .fwd_value_i (ex_mem_wb_ff.result),
    .rs1_fwd_i   (rs1_fwd),
    .rs2_fwd_i   (rs2_fwd),
    .op1_o       (op1),
    .op2_o       (op2),
    .res_o       (alu_res)
  );

  ex_branch u_branch (
    .id_ex_i      (id_ex_i),
    .op1_i        (op1),
    .op2_i        (op2),
    .alu_res_i    (alu_res),
    .take_o       (take),
    .target_o     (target),
    .misaligned_o (misaligned)
  );

  ex_csr u_csr (
    .clk          (clk),
    .rst_i        (rst_i),
    .stall_i      (lsu_bp_i),
    .kill_i       (csr_kill),
    .csr_i        (id_ex_i.csr),
    .rs1_data_i   (op1),
    .imm_i        (id_ex_i.imm),
    .pc_addr_i    (id_ex_i.pc_dec),
    .ecall_i      (id_ex_i.ecall),
    .mret_i       (id_ex_i.mret),
    .misaligned_i (misaligned),
    .bad_target_i (target),
    .csr_rd_o     (csr_rdata),
    .trap_o       (trap)
  );

endmodule

// File: design/ex_regfile.sv
/* Integer register file */

`include "ex_defines.svh"

module ex_regfile (
  input  logic           clk,
  input  logic           rst_i,
  input  ex_pkg::raddr_t rs1_addr_i,
  input  ex_pkg::raddr_t rs2_addr_i,
  output ex_pkg::rdata_t rs1_data_o,
  output ex_pkg::rdata_t rs2_data_o,
  input  logic           we_i,
  input  ex_pkg::raddr_t rd_addr_i,
  input  ex_pkg::rdata_t rd_data_i
);

  ex_pkg::rdata_t regs_ff [`EX_NREGS];

  always_ff @(posedge clk) begin
    if (rst_i) begin
      regs_ff <= '{default: '0};
    end else if (we_i && (rd_addr_i != '0)) begin
      regs_ff[rd_addr_i] <= rd_data_i;
    end
  end

  // x0 is hardwired
  assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs_ff[rs1_addr_i];
  assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs_ff[rs2_addr_i];

endmodule

// File: design/ex_top.sv
/* Execute stage with register file */

module ex_top (
  input  logic                 clk,
  input  logic                 rst_i,
  input  ex_pkg::s_id_ex_t     id_ex_i,
  input  logic                 id_valid_i,
  output logic                 id_ready_o,
  input  logic                 lsu_bp_i,
  output ex_pkg::s_ex_mem_wb_t ex_mem_wb_o,
  output ex_pkg::s_lsu_op_t    lsu_o,
  output logic                 fetch_req_o,
  output ex_pkg::pc_t          fetch_addr_o
);

  ex_pkg::rdata_t rs1_data;
  ex_pkg::rdata_t rs2_data;
  // Write-back waits out a stall
  wire            wb_we = ex_mem_wb_o.we_rd & ~lsu_bp_i;

  ex_regfile u_regfile (
    .clk        (clk),
    .rst_i      (rst_i),
    .rs1_addr_i (id_ex_i.rs1_addr),
    .rs2_addr_i (id_ex_i.rs2_addr),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .we_i       (wb_we),
    .rd_addr_i  (ex_mem_wb_o.rd_addr),
    .rd_data_i  (ex_mem_wb_o.result)
  );

  execute u_execute (
    .clk          (clk),
    .rst_i        (rst_i),
    .id_ex_i      (id_ex_i),
    .rs1_data_i   (rs1_data),
    .rs2_data_i   (rs2_data),
    .id_valid_i   (id_valid_i),
    .id_ready_o   (id_ready_o),
    .lsu_bp_i     (lsu_bp_i),
    .ex_mem_wb_o  (ex_mem_wb_o),
    .lsu_o        (lsu_o),
    .fetch_req_o  (fetch_req_o),
    .fetch_addr_o (fetch_addr_o)
  );

endmodule

// File: testbench/tb_ex_model.svh
/* Execute stage reference model */

`ifndef TB_EX_MODEL_SVH
`define TB_EX_MODEL_SVH

ex_pkg::rdata_t m_regs [32];
ex_pkg::rdata_t m_mtvec;
ex_pkg::rdata_t m_mepc;
ex_pkg::rdata_t m_mcause;
ex_pkg::rdata_t m_mtval;
ex_pkg::rdata_t m_mscratch;
logic           m_redir_req;
ex_pkg::pc_t    m_redir_addr;
logic           m_we;
ex_pkg::raddr_t m_rd;
ex_pkg::rdata_t m_result;

task automatic model_reset();
  for (int i = 0; i < 32; i++) begin
    m_regs[i] = '0;
  end
  m_mtvec      = `EX_MTVEC_RST;
  m_mepc       = '0;
  m_mcause     = '0;
  m_mtval      = '0;
  m_mscratch   = '0;
  m_redir_req  = 1'b0;
  m_redir_addr = '0;
  m_we         = 1'b0;
  m_rd         = '0;
  m_result     = '0;
endtask

function automatic ex_pkg::rdata_t reg_value(ex_pkg::raddr_t a);
  return (a == 5'd0) ? 32'd0 : m_regs[a];
endfunction

function automatic ex_pkg::rdata_t operand(ex_pkg::src_op_t sel, ex_pkg::rdata_t r,
                                           ex_pkg::rdata_t imm, ex_pkg::pc_t pc);
  if (sel == ex_pkg::REG_RF) return r;
  if (sel == ex_pkg::IMM) return imm;
  if (sel == ex_pkg::PC) return pc;
  return 32'd0;
endfunction

function automatic ex_pkg::rdata_t alu_calc(ex_pkg::s_id_ex_t ins, ex_pkg::rdata_t a,
                                            ex_pkg::rdata_t b);
  case (ins.f3)
    ex_pkg::F3_ADD_SUB: return ins.f7_sub ? a - b : a + b;
    ex_pkg::F3_SLL:     return a << b[4:0];
    ex_pkg::F3_SLT:     return {31'd0, $signed(a) < $signed(b)};
    ex_pkg::F3_SLTU:    return {31'd0, a < b};
    ex_pkg::F3_XOR:     return a ^ b;
    ex_pkg::F3_SRL_SRA: return ins.rshift_arith ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
    ex_pkg::F3_OR:      return a | b;
    default:            return a & b;
  endcase
endfunction

function automatic logic branch_cond(logic [2:0] f3, ex_pkg::rdata_t a, ex_pkg::rdata_t b);
  case (f3)
    3'd0:    return a == b;
    3'd1:    return a != b;
    3'd4:    return $signed(a) < $signed(b);
    3'd5:    return $signed(a) >= $signed(b);
    3'd6:    return a < b;
    3'd7:    return a >= b;
    default: return 1'b0;
  endcase
endfunction

function automatic ex_pkg::rdata_t csr_value(logic [11:0] addr);
  case (addr)
    12'h305: return m_mtvec;
    12'h340: return m_mscratch;
    12'h341: return m_mepc;
    12'h342: return m_mcause;
    12'h343: return m_mtval;
    default: return 32'd0;
  endcase
endfunction

task automatic csr_store(logic [11:0] addr, ex_pkg::rdata_t v);
  case (addr)
    12'h305: m_mtvec    = v;
    12'h340: m_mscratch = v;
    12'h341: m_mepc     = v;
    12'h342: m_mcause   = v;
    12'h343: m_mtval    = v;
    default: ;
  endcase
endtask

// One clock edge of the stage, given the inputs of the cycle before it
task automatic model_step(ex_pkg::s_id_ex_t ins, logic valid, logic bp);
  ex_pkg::rdata_t a;
  ex_pkg::rdata_t b;
  ex_pkg::rdata_t res;
  ex_pkg::rdata_t old;
  ex_pkg::rdata_t src;
  ex_pkg::rdata_t wv;
  ex_pkg::pc_t    target;
  ex_pkg::pc_t    tr_addr;
  logic           take;
  logic           mis;
  logic           live;
  logic           tr;
  if (bp) return;
  a      = operand(ins.rs1_op, reg_value(ins.rs1_addr), ins.imm, ins.pc_dec);
  b      = operand(ins.rs2_op, reg_value(ins.rs2_addr), ins.imm, ins.pc_dec);
  res    = alu_calc(ins, a, b);
  take   = ins.jump || (ins.branch && branch_cond(ins.f3, a, b));
  target = ins.jump ? {res[31:1], 1'b0} : ins.pc_dec + ins.imm;
  mis    = take && (target[1:0] != 2'b00);
  live   = valid && !m_redir_req;
  tr     = live && (ins.ecall || mis || ins.mret);
  tr_addr = (ins.ecall || mis) ? m_mtvec : m_mepc;
  old    = csr_value(ins.csr.addr);

  m_we = live && !tr && ins.we_rd && (ins.lsu == ex_pkg::LSU_NONE);
  m_rd = ins.rd_addr;
  if (ins.jump) m_result = ins.pc_dec + 32'd4;
  else if (ins.csr.op != ex_pkg::CSR_NONE) m_result = old;
  else m_result = res;
  if (m_we && ins.rd_addr != 5'd0) m_regs[ins.rd_addr] = m_result;

  if (live && (ins.ecall || mis)) begin
    m_mepc   = ins.pc_dec;
    m_mcause = ins.ecall ? 32'd11 : 32'd0;
    m_mtval  = ins.ecall ? 32'd0 : target;
  end else if (live && ins.csr.op != ex_pkg::CSR_NONE) begin
    src = (ins.csr.op inside {ex_pkg::CSR_RWI, ex_pkg::CSR_RSI, ex_pkg::CSR_RCI}) ?
          {27'd0, ins.imm[4:0]} : a;
    if (ins.csr.op inside {ex_pkg::CSR_RW, ex_pkg::CSR_RWI}) wv = src;
    else if (ins.csr.op inside {ex_pkg::CSR_RS, ex_pkg::CSR_RSI}) wv = old | src;
    else wv = old & ~src;
    csr_store(ins.csr.addr, wv);
  end

  m_redir_req  = live && (tr || take);
  m_redir_addr = tr ? tr_addr : target;
endtask

`endif

// File: testbench/tb_ex_top.sv
/* Execute stage testbench */

`include "ex_defines.svh"

module tb_ex_top;

  localparam int PERIOD  = 4;
  localparam int N_TESTS = 5;
  localparam int N_INSTR = 300;
  localparam int TIMEOUT = (N_TESTS * N_INSTR * 4 + 10 + 8) * PERIOD;

  logic                 clk;
  logic                 rst_i;
  ex_pkg::s_id_ex_t     id_ex_i;
  logic                 id_valid_i;
  logic                 id_ready_o;
  logic                 lsu_bp_i;
  ex_pkg::s_ex_mem_wb_t ex_mem_wb_o;
  ex_pkg::s_lsu_op_t    lsu_o;
  logic                 fetch_req_o;
  ex_pkg::pc_t          fetch_addr_o;

  logic [31:0] lfsr_state;
  int          errors;
  int          checks;

  `include "tb_ex_model.svh"

  ex_top ex_top_inst (
    .clk          (clk),
    .rst_i        (rst_i),
    .id_ex_i      (id_ex_i),
    .id_valid_i   (id_valid_i),
    .id_ready_o   (id_ready_o),
    .lsu_bp_i     (lsu_bp_i),
    .ex_mem_wb_o  (ex_mem_wb_o),
    .lsu_o        (lsu_o),
    .fetch_req_o  (fetch_req_o),
    .fetch_addr_o (fetch_addr_o)
  );

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(TIMEOUT);
    $display("timeout: the instruction stream did not finish in time");
    $display("STATUS: FAIL");
    $finish;
  end

  // Fibonacci LFSR, taps 32 22 2 1
  task automatic rand_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = {lfsr_state[30:0],
                    lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
      val = {val[30:0], lfsr_state[0]};
    end
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic gen_instr(input int t, output ex_pkg::s_id_ex_t ins);
    logic [31:0] k;
    logic [31:0] r;
    int          kind;
    int          t4_kinds [8] = '{0, 12, 12, 12, 13, 14, 10, 11};
    rand_bits(4, k);
    case (t)
      1:       kind = k % 7;
      2:       kind = k % 9;
      3:       kind = (k < 8) ? k % 7 : 9 + k % 3;
      4:       kind = t4_kinds[k % 8];
      default: kind = (k == 15) ? 0 : k;
    endcase
    ins = '0;
    rand_bits(16, r);
    ins.pc_dec = {14'd0, r[15:0], 2'b00};
    // Narrow register range in test 2 for dense dependencies
    rand_bits((t == 2) ? 2 : 3, r);
    ins.rs1_addr = r[4:0];
    rand_bits((t == 2) ? 2 : 3, r);
    ins.rs2_addr = r[4:0];
    rand_bits((t == 2) ? 2 : 3, r);
    ins.rd_addr = r[4:0];
    rand_bits(12, r);
    ins.imm = {{20{r[11]}}, r[11:0]};
    rand_bits(5, r);
    ins.f3 = ex_pkg::alu_f3_t'(r[2:0]);
    ins.f7_sub = r[3] && (r[2:0] == 3'd0);
    ins.rshift_arith = r[4];
    ins.rs1_op = ex_pkg::REG_RF;
    ins.rs2_op = ex_pkg::REG_RF;
    ins.we_rd = 1'b1;
    if (kind == 4 || kind == 5) begin
      ins.rs2_op = ex_pkg::IMM;
      ins.f7_sub = 1'b0;
    end else if (kind == 6) begin
      rand_bits(32, r);
      ins.imm = r;
      ins.rs1_op = r[0] ? ex_pkg::PC : ex_pkg::ZERO;
      ins.rs2_op = ex_pkg::IMM;
      ins.f3 = ex_pkg::F3_ADD_SUB;
      ins.f7_sub = 1'b0;
    end else if (kind == 7 || kind == 8) begin
      rand_bits(2, r);
      ins.lsu_w = (r[1:0] == 2'd3) ? ex_pkg::LSU_WORD : ex_pkg::lsu_w_t'(r[1:0]);
      ins.lsu = (kind == 7) ? ex_pkg::LSU_LOAD : ex_pkg::LSU_STORE;
      ins.we_rd = (kind == 7);
      ins.rs2_op = ex_pkg::IMM;
      ins.f3 = ex_pkg::F3_ADD_SUB;
      ins.f7_sub = 1'b0;
    end else if (kind == 9) begin
      rand_bits(3, r);
      ins.f3 = ex_pkg::alu_f3_t'((r[2:1] == 2'b01) ? {1'b0, r[1:0]} & 3'd1 : r[2:0]);
      ins.branch = 1'b1;
      ins.we_rd = 1'b0;
      ins.imm = {ins.imm[31:1], 1'b0};
    end else if (kind == 10 || kind == 11) begin
      ins.jump = 1'b1;
      ins.rs1_op = (kind == 10) ? ex_pkg::PC : ex_pkg::REG_RF;
      ins.rs2_op = ex_pkg::IMM;
      ins.f3 = ex_pkg::F3_ADD_SUB;
      ins.f7_sub = 1'b0;
      if (kind == 10) ins.imm = {ins.imm[31:1], 1'b0};
    end else if (kind == 12) begin
      rand_bits(6, r);
      ins.csr.op = (r[2:0] == 3'd0 || r[2:0] == 3'd4) ? ex_pkg::CSR_RW : ex_pkg::csr_op_t'(r[2:0]);
      case (r[5:3])
        3'd0, 3'd6: ins.csr.addr = 12'h305;
        3'd1:       ins.csr.addr = 12'h340;
        3'd2, 3'd7: ins.csr.addr = 12'h341;
        3'd3:       ins.csr.addr = 12'h342;
        3'd4:       ins.csr.addr = 12'h343;
        default:    ins.csr.addr = 12'h300;
      endcase
      ins.rs2_op = ex_pkg::ZERO;
    end else if (kind == 13 || kind == 14) begin
      ins.ecall = (kind == 13);
      ins.mret = (kind == 14);
      ins.we_rd = 1'b0;
      ins.rs1_op = ex_pkg::ZERO;
      ins.rs2_op = ex_pkg::ZERO;
    end
  endtask

  // Present one instruction and hold it until taken
  task automatic issue(input int t);
    ex_pkg::s_id_ex_t ins;
    logic [31:0]      r;
    logic [31:0]      bp_bits;
    logic             bp;
    gen_instr(t, ins);
    rand_bits(3, r);
    bp = 1'b0;
    if (t == 5) begin
      rand_bits(2, bp_bits);
      bp = (bp_bits[1:0] == 2'd0);
    end
    @(posedge clk);
    id_ex_i    <= ins;
    id_valid_i <= (r[2:0] != 3'd0);
    lsu_bp_i   <= bp;
    @(negedge clk);
    while (id_valid_i && !id_ready_o) begin
      @(posedge clk);
      rand_bits(2, r);
      lsu_bp_i <= (r[1:0] == 2'd0);
      @(negedge clk);
    end
  endtask

  always @(negedge clk) begin
    if (rst_i) begin
      model_reset();
    end else begin
      check_val("id_ready_o", {31'd0, id_ready_o}, {31'd0, !lsu_bp_i});
      check_val("fetch_req_o", {31'd0, fetch_req_o}, {31'd0, m_redir_req && !lsu_bp_i});
      if (fetch_req_o) check_val("fetch_addr_o", fetch_addr_o, m_redir_addr);
      check_val("ex_mem_wb_o.we_rd", {31'd0, ex_mem_wb_o.we_rd}, {31'd0, m_we});
      if (m_we) begin
        check_val("ex_mem_wb_o.rd_addr", {27'd0, ex_mem_wb_o.rd_addr}, {27'd0, m_rd});
        check_val("ex_mem_wb_o.result", ex_mem_wb_o.result, m_result);
      end
      check_val("lsu_o.op_typ", 32'(lsu_o.op_typ),
                (id_valid_i && !m_redir_req) ? 32'(id_ex_i.lsu) : 32'(ex_pkg::LSU_NONE));
      if (lsu_o.op_typ != ex_pkg::LSU_NONE) begin
        check_val("lsu_o.width", 32'(lsu_o.width), 32'(id_ex_i.lsu_w));
        check_val("lsu_o.addr", lsu_o.addr,
                  alu_calc(id_ex_i,
                           operand(id_ex_i.rs1_op, reg_value(id_ex_i.rs1_addr),
                                   id_ex_i.imm, id_ex_i.pc_dec),
                           operand(id_ex_i.rs2_op, reg_value(id_ex_i.rs2_addr),
                                   id_ex_i.imm, id_ex_i.pc_dec)));
        if (lsu_o.op_typ == ex_pkg::LSU_STORE) begin
          check_val("lsu_o.wdata", lsu_o.wdata, reg_value(id_ex_i.rs2_addr));
        end
      end
      check_val("x0", ex_top_inst.u_regfile.regs_ff[0], 32'd0);
      model_step(id_ex_i, id_valid_i, lsu_bp_i);
    end
  end

  initial begin
    string names [N_TESTS] = '{"alu", "forwarding", "branch_jump", "csr_trap", "stall_lsu"};
    int    start_err;
    lfsr_state = 32'h519f5c39;
    errors     = 0;
    checks     = 0;
    rst_i      = 1'b1;
    id_ex_i    = '0;
    id_valid_i = 1'b0;
    lsu_bp_i   = 1'b0;
    repeat (10) @(posedge clk);
    rst_i <= 1'b0;
    for (int t = 1; t <= N_TESTS; t++) begin
      start_err = errors;
      for (int i = 0; i < N_INSTR; i++) begin
        issue(t);
      end
      $display("test %0d %s: %0d errors", t, names[t-1], errors - start_err);
    end
    @(posedge clk);
    id_valid_i <= 1'b0;
    lsu_bp_i   <= 1'b0;
    repeat (3) @(negedge clk);
    $display("tests %0d, checks %0d, errors %0d", N_TESTS, checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// File: flist.f
+incdir+design
+incdir+testbench
design/ex_pkg.sv
design/ex_alu.sv
design/ex_branch.sv
design/ex_csr.sv
design/execute.sv
design/ex_regfile.sv
design/ex_top.sv
testbench/tb_ex_top.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary -f flist.f --top-module tb_ex_top -Mdir obj_dir
	./obj_dir/Vtb_ex_top | tee sim.log
	grep -q "STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
